// File: filelist.f
source/video_pkg.sv
source/video_ports.sv
source/video_sync.sv
source/video_fetch.sv
source/video_linebuf.sv
source/video_render.sv
source/video_top.sv
tests/tb_dram_model.sv
tests/tb_video_top.sv

// File: run.sh
#!/bin/sh
# build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_video_top \
	-Mdir obj_dir -o tb_video_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_video_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1

// File: source/video_fetch.sv
module video_fetch (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    fetch_go,
	input  video_pkg::row_t         fetch_row,
	input  video_pkg::pix_t         vpage,
	input  video_pkg::pix_t         gy_offs,
	input  video_pkg::xoffs_t       gx_offs,
	input  logic                    gfx_on,
	output video_pkg::dram_addr_t   dram_addr,
	output logic                    dram_req,
	input  logic                    dram_next,
	input  video_pkg::dram_data_t   dram_rdata,
	output logic                    buf_we,
	output video_pkg::word_idx_t    buf_waddr,
	output video_pkg::dram_data_t   buf_wdata
);

	video_pkg::fetch_state_t state;
	video_pkg::word_idx_t    widx;
	video_pkg::pix_t         page;
	video_pkg::pix_t         yrow;
	video_pkg::xoffs_t       xcol;
	video_pkg::pix_t         yrow_start;
	logic                    start;
	logic                    word_done;
	logic                    last_word;

	// bitmap row of the requested screen line wrapping at 256
	assign yrow_start = gy_offs + video_pkg::pix_t'(fetch_row) -
			video_pkg::pix_t'(video_pkg::V_PIX_BEG);

	assign start     = (state == video_pkg::IDLE) && fetch_go && gfx_on;
	assign word_done = (state == video_pkg::REQ) && dram_next;
	assign last_word = (widx == video_pkg::word_idx_t'(video_pkg::LINE_WORDS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= video_pkg::IDLE;
			widx  <= '0;
		end else begin
			case (state)
				video_pkg::IDLE: begin
					widx <= '0;
					if (start)
						state <= video_pkg::REQ;
				end
				video_pkg::REQ: begin
					if (dram_next) begin
						widx <= widx + 4'd1;
						if (last_word)
							state <= video_pkg::DONE;
					end
				end
				video_pkg::DONE: state <= video_pkg::IDLE;
				default: state <= video_pkg::IDLE;
			endcase
		end
	end

	// address fields captured at start and column stepped per word
	always_ff @(posedge clk) begin
		if (start) begin
			page <= vpage;
			yrow <= yrow_start;
			xcol <= gx_offs;
		end else if (word_done) begin
			xcol <= xcol + 5'd1;
		end
	end

	// request held with a stable address until next
	assign dram_req  = (state == video_pkg::REQ);
	assign dram_addr = {page, yrow, xcol};

	// word written to the buffer in the cycle of its next
	assign buf_we    = word_done;
	assign buf_waddr = widx;
	assign buf_wdata = dram_rdata;

endmodule

// File: source/video_linebuf.sv
module video_linebuf (
	input  logic                    clk,
	input  logic                    line_par,
	input  logic                    buf_we,
	input  video_pkg::word_idx_t    buf_waddr,
	input  video_pkg::dram_data_t   buf_wdata,
	input  video_pkg::word_idx_t    raddr,
	output video_pkg::dram_data_t   rdata
);

	// two banks, indexed by line parity
	video_pkg::dram_data_t mem [0:1][0:15];
	logic                  wbank;

	// fetcher fills the bank of the next line
	assign wbank = ~line_par;

	always_ff @(posedge clk) begin
		if (buf_we)
			mem[wbank][buf_waddr] <= buf_wdata;
	end

	// display reads the bank of the current line
	always_ff @(posedge clk) begin
		rdata <= mem[line_par][raddr];
	end

endmodule

// File: source/video_pkg.sv
package video_pkg;

	// counter and data widths
	typedef logic [6:0]  col_t;
	typedef logic [5:0]  row_t;
	typedef logic [20:0] dram_addr_t;
	typedef logic [15:0] dram_data_t;
	typedef logic [7:0]  pix_t;
	typedef logic [14:0] color_t;
	typedef logic [3:0]  word_idx_t;
	typedef logic [4:0]  xoffs_t;

	// line fetch sequencer
	typedef enum logic [1:0] {
		IDLE,
		REQ,
		DONE
	} fetch_state_t;

	// horizontal geometry, in pixel clocks
	localparam col_t H_TOTAL   = 7'd96;
	localparam col_t H_SYNC    = 7'd6;
	localparam col_t H_PIX_BEG = 7'd16;
	localparam col_t H_PIX_END = 7'd48;

	// vertical geometry, in lines
	localparam row_t V_TOTAL   = 6'd40;
	localparam row_t V_SYNC    = 6'd2;
	localparam row_t V_PIX_BEG = 6'd8;
	localparam row_t V_PIX_END = 6'd24;

	// unblanked area, border wraps the pixel window on all sides
	localparam col_t H_VIS_BEG = 7'd8;
	localparam col_t H_VIS_END = 7'd56;
	localparam row_t V_VIS_BEG = V_PIX_BEG - 6'd4;
	localparam row_t V_VIS_END = V_PIX_END + 6'd4;

	// one bitmap line is 32 pixels of one byte each
	localparam int LINE_WORDS = 16;

endpackage

// File: source/video_ports.sv
module video_ports (
	input  logic                clk,
	input  logic                reset,
	input  video_pkg::pix_t     d,
	input  logic                border_wr,
	input  logic                vpage_wr,
	input  logic                gx_offs_wr,
	input  logic                gy_offs_wr,
	input  logic                vconf_wr,
	input  logic                frame_start,
	output video_pkg::pix_t     border,
	output video_pkg::pix_t     vpage,
	output video_pkg::pix_t     gy_offs,
	output video_pkg::xoffs_t   gx_offs,
	output logic                gfx_on
);

	video_pkg::pix_t   border_s;
	video_pkg::pix_t   vpage_s;
	video_pkg::pix_t   gy_offs_s;
	video_pkg::xoffs_t gx_offs_s;
	logic              gfx_on_s;

	// cpu writes land in the staging set
	always_ff @(posedge clk) begin
		if (reset) begin
			border_s  <= '0;
			vpage_s   <= '0;
			gy_offs_s <= '0;
			gx_offs_s <= '0;
			gfx_on_s  <= 1'b0;
		end else begin
			if (border_wr)
				border_s <= d;
			if (vpage_wr)
				vpage_s <= d;
			if (gx_offs_wr)
				gx_offs_s <= d[4:0];
			if (gy_offs_wr)
				gy_offs_s <= d;
			// only the graphics enable is kept from vconf
			if (vconf_wr)
				gfx_on_s <= d[0];
		end
	end

	// active set follows the staging set once per frame
	always_ff @(posedge clk) begin
		if (reset) begin
			border  <= '0;
			vpage   <= '0;
			gy_offs <= '0;
			gx_offs <= '0;
			gfx_on  <= 1'b0;
		end else if (frame_start) begin
			border  <= border_s;
			vpage   <= vpage_s;
			gy_offs <= gy_offs_s;
			gx_offs <= gx_offs_s;
			gfx_on  <= gfx_on_s;
		end
	end

endmodule

// File: source/video_render.sv
module video_render (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    in_window,
	input  logic                    gfx_on,
	input  logic                    hsync_raw,
	input  logic                    vsync_raw,
	input  logic                    int_start,
	input  video_pkg::col_t         col_idx,
	input  video_pkg::dram_data_t   rdata,
	input  video_pkg::pix_t         border,
	input  logic                    cram_we,
	input  video_pkg::pix_t         cram_addr,
	input  video_pkg::color_t       cram_wdata,
	output video_pkg::word_idx_t    raddr,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    blank,
	output logic                    int_out,
	output video_pkg::color_t       rgb
);

	video_pkg::color_t cram [0:255];
	video_pkg::col_t   pofs;
	video_pkg::row_t   vline;
	video_pkg::pix_t   pix;
	video_pkg::pix_t   idx;
	logic              vis;
	logic              par_q;
	logic              win_q;
	logic              vis_q;
	logic              hs_q;
	logic              vs_q;
	logic              int_q;

	// pixel offset in the window, two pixels per word
	assign pofs  = col_idx - video_pkg::H_PIX_BEG;
	assign raddr = pofs[4:1];

	// line count realigned each frame by int_start
	always_ff @(posedge clk) begin
		if (reset)
			vline <= '0;
		else if (int_start)
			vline <= '0;
		else if (col_idx == video_pkg::H_TOTAL - 7'd1)
			vline <= vline + 6'd1;
	end

	assign vis = (vline >= video_pkg::V_VIS_BEG) && (vline < video_pkg::V_VIS_END) &&
			(col_idx >= video_pkg::H_VIS_BEG) && (col_idx < video_pkg::H_VIS_END);

	// stage 1, buffer read in flight
	always_ff @(posedge clk) begin
		if (reset) begin
			par_q <= 1'b0;
			win_q <= 1'b0;
			vis_q <= 1'b0;
			hs_q  <= 1'b1;
			vs_q  <= 1'b1;
			int_q <= 1'b0;
		end else begin
			par_q <= pofs[0];
			win_q <= in_window;
			vis_q <= vis;
			hs_q  <= hsync_raw;
			vs_q  <= vsync_raw;
			int_q <= int_start;
		end
	end

	// odd pixels live in the high byte
	assign pix = par_q ? rdata[15:8] : rdata[7:0];
	assign idx = (win_q && gfx_on) ? pix : border;

	always_ff @(posedge clk) begin
		if (cram_we)
			cram[cram_addr] <= cram_wdata;
	end

	// stage 2, palette lookup and output registers
	always_ff @(posedge clk) begin
		if (reset) begin
			rgb     <= '0;
			blank   <= 1'b1;
			hsync   <= 1'b1;
			vsync   <= 1'b1;
			int_out <= 1'b0;
		end else begin
			rgb     <= vis_q ? cram[idx] : '0;
			blank   <= ~vis_q;
			hsync   <= hs_q;
			vsync   <= vs_q;
			int_out <= int_q;
		end
	end

endmodule

// File: source/video_sync.sv
module video_sync (
	input  logic              clk,
	input  logic              reset,
	output logic              hsync_raw,
	output logic              vsync_raw,
	output logic              line_start,
	output logic              frame_start,
	output logic              fetch_go,
	output logic              int_start,
	output logic              in_window,
	output logic              line_par,
	output video_pkg::row_t   fetch_row,
	output video_pkg::col_t   col_idx
);

	video_pkg::col_t col;
	video_pkg::row_t row;
	logic            col_last;
	logic            row_last;
	logic            hpix;
	logic            vpix;
	logic            vfetch;

	assign col_last = (col == video_pkg::H_TOTAL - 7'd1);
	assign row_last = (row == video_pkg::V_TOTAL - 6'd1);

	// free-running raster position
	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (col_last) begin
			col <= '0;
			if (row_last)
				row <= '0;
			else
				row <= row + 6'd1;
		end else begin
			col <= col + 7'd1;
		end
	end

	// syncs, active low, at the start of line and frame
	assign hsync_raw = ~(col < video_pkg::H_SYNC);
	assign vsync_raw = ~(row < video_pkg::V_SYNC);

	assign line_start  = (col == '0);
	assign frame_start = line_start && (row == '0);

	// frame interrupt on the first sync cycle of line 0
	assign int_start = frame_start;

	// pixel window
	assign hpix = (col >= video_pkg::H_PIX_BEG) && (col < video_pkg::H_PIX_END);
	assign vpix = (row >= video_pkg::V_PIX_BEG) && (row < video_pkg::V_PIX_END);
	assign in_window = hpix && vpix;

	// fetch one line ahead, from the line before the window
	// to the line before its last
	assign vfetch = (row >= video_pkg::V_PIX_BEG - 6'd1) &&
			(row <= video_pkg::V_PIX_END - 6'd2);
	assign fetch_go = line_start && vfetch;

	// line the fetcher is preparing
	assign fetch_row = row + 6'd1;

	// buffer bank select
	assign line_par = row[0];

	assign col_idx = col;

endmodule

// File: source/video_top.sv
module video_top (
	input  logic                    clk,
	input  logic                    reset,

	// cpu port writes
	input  video_pkg::pix_t         d,
	input  logic                    border_wr,
	input  logic                    vpage_wr,
	input  logic                    gx_offs_wr,
	input  logic                    gy_offs_wr,
	input  logic                    vconf_wr,
	input  logic                    cram_we,
	input  video_pkg::pix_t         cram_addr,
	input  video_pkg::color_t       cram_wdata,

	// dram read port
	output video_pkg::dram_addr_t   dram_addr,
	output logic                    dram_req,
	input  logic                    dram_next,
	input  video_pkg::dram_data_t   dram_rdata,

	// video out
	output video_pkg::color_t       rgb,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    blank,
	output logic                    int_start
);

	// active port registers
	video_pkg::pix_t       border;
	video_pkg::pix_t       vpage;
	video_pkg::pix_t       gy_offs;
	video_pkg::xoffs_t     gx_offs;
	logic                  gfx_on;

	// raster timing
	logic                  hsync_raw;
	logic                  vsync_raw;
	logic                  frame_start;
	logic                  fetch_go;
	logic                  int_raw;
	logic                  in_window;
	logic                  line_par;
	video_pkg::row_t       fetch_row;
	video_pkg::col_t       col_idx;

	// line buffer
	logic                  buf_we;
	video_pkg::word_idx_t  buf_waddr;
	video_pkg::dram_data_t buf_wdata;
	video_pkg::word_idx_t  raddr;
	video_pkg::dram_data_t rdata;

	video_ports video_ports (
		.clk         (clk),
		.reset       (reset),
		.d           (d),
		.border_wr   (border_wr),
		.vpage_wr    (vpage_wr),
		.gx_offs_wr  (gx_offs_wr),
		.gy_offs_wr  (gy_offs_wr),
		.vconf_wr    (vconf_wr),
		.frame_start (frame_start),
		.border      (border),
		.vpage       (vpage),
		.gy_offs     (gy_offs),
		.gx_offs     (gx_offs),
		.gfx_on      (gfx_on)
	);

	video_sync video_sync (
		.clk         (clk),
		.reset       (reset),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw),
		.line_start  (),
		.frame_start (frame_start),
		.fetch_go    (fetch_go),
		.int_start   (int_raw),
		.in_window   (in_window),
		.line_par    (line_par),
		.fetch_row   (fetch_row),
		.col_idx     (col_idx)
	);

	video_fetch video_fetch (
		.clk        (clk),
		.reset      (reset),
		.fetch_go   (fetch_go),
		.fetch_row  (fetch_row),
		.vpage      (vpage),
		.gy_offs    (gy_offs),
		.gx_offs    (gx_offs),
		.gfx_on     (gfx_on),
		.dram_addr  (dram_addr),
		.dram_req   (dram_req),
		.dram_next  (dram_next),
		.dram_rdata (dram_rdata),
		.buf_we     (buf_we),
		.buf_waddr  (buf_waddr),
		.buf_wdata  (buf_wdata)
	);

	video_linebuf video_linebuf (
		.clk       (clk),
		.line_par  (line_par),
		.buf_we    (buf_we),
		.buf_waddr (buf_waddr),
		.buf_wdata (buf_wdata),
		.raddr     (raddr),
		.rdata     (rdata)
	);

	video_render video_render (
		.clk        (clk),
		.reset      (reset),
		.in_window  (in_window),
		.gfx_on     (gfx_on),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.int_start  (int_raw),
		.col_idx    (col_idx),
		.rdata      (rdata),
		.border     (border),
		.cram_we    (cram_we),
		.cram_addr  (cram_addr),
		.cram_wdata (cram_wdata),
		.raddr      (raddr),
		.hsync      (hsync),
		.vsync      (vsync),
		.blank      (blank),
		.int_out    (int_start),
		.rgb        (rgb)
	);

endmodule

// File: tests/tb_dram_model.sv
module tb_dram_model (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    dram_req,
	input  video_pkg::dram_addr_t   dram_addr,
	output logic                    dram_next,
	output video_pkg::dram_data_t   dram_rdata
);

	logic [31:0] lfsr;
	logic        busy;
	logic [1:0]  wait_cnt;
	logic [1:0]  delay;

	// one shift of a 32-bit galois lfsr
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// low address bits with the top page bits folded into the high byte
	function automatic video_pkg::dram_data_t fill(input video_pkg::dram_addr_t a);
		return a[15:0] ^ {3'b000, a[20:16], 8'h00} ^ 16'hA5C3;
	endfunction

	initial begin
		dram_next  <= 1'b0;
		dram_rdata <= '0;
	end

	always @(posedge clk) begin
		if (reset) begin
			lfsr = 32'd78583;
			busy       <= 1'b0;
			wait_cnt   <= 2'd0;
			dram_next  <= 1'b0;
			dram_rdata <= '0;
		end else if (dram_next) begin
			// fetcher moves to the next address on this edge
			dram_next <= 1'b0;
		end else if (busy) begin
			if (wait_cnt == 2'd0) begin
				dram_next  <= 1'b1;
				dram_rdata <= fill(dram_addr);
				busy       <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end else if (dram_req) begin
			// two lfsr bits give a 0 to 3 cycle latency
			delay[0] = lfsr[0];
			lfsr = lfsr_step(lfsr);
			delay[1] = lfsr[0];
			lfsr = lfsr_step(lfsr);
			if (delay == 2'd0) begin
				dram_next  <= 1'b1;
				dram_rdata <= fill(dram_addr);
			end else begin
				busy     <= 1'b1;
				wait_cnt <= delay - 2'd1;
			end
		end
	end

endmodule

// File: tests/tb_video_top.sv
module tb_video_top;

	logic                    clk = 1'b0;
	logic                    reset;
	video_pkg::pix_t         d;
	logic                    border_wr;
	logic                    vpage_wr;
	logic                    gx_offs_wr;
	logic                    gy_offs_wr;
	logic                    vconf_wr;
	logic                    cram_we;
	video_pkg::pix_t         cram_addr;
	video_pkg::color_t       cram_wdata;
	video_pkg::dram_addr_t   dram_addr;
	logic                    dram_req;
	logic                    dram_next;
	video_pkg::dram_data_t   dram_rdata;
	video_pkg::color_t       rgb;
	logic                    hsync;
	logic                    vsync;
	logic                    blank;
	logic                    int_start;

	// cpu register values as staged and as in effect for the current frame
	video_pkg::pix_t   stg_border;
	video_pkg::pix_t   stg_vpage;
	video_pkg::pix_t   stg_gy;
	video_pkg::xoffs_t stg_gx;
	logic              stg_gfx;
	video_pkg::pix_t   act_border;
	video_pkg::pix_t   act_vpage;
	video_pkg::pix_t   act_gy;
	video_pkg::xoffs_t act_gx;
	logic              act_gfx;

	// raster position recovered from the sync outputs
	int   col;
	int   line;
	int   frame_no = -1;
	logic hs_d;
	logic vs_d;
	logic h_seen;
	logic v_seen;

	int gfx_checks = 0;
	int border_checks = 0;
	int off_checks = 0;

	video_top DUT (
		.clk        (clk),
		.reset      (reset),
		.d          (d),
		.border_wr  (border_wr),
		.vpage_wr   (vpage_wr),
		.gx_offs_wr (gx_offs_wr),
		.gy_offs_wr (gy_offs_wr),
		.vconf_wr   (vconf_wr),
		.cram_we    (cram_we),
		.cram_addr  (cram_addr),
		.cram_wdata (cram_wdata),
		.dram_addr  (dram_addr),
		.dram_req   (dram_req),
		.dram_next  (dram_next),
		.dram_rdata (dram_rdata),
		.rgb        (rgb),
		.hsync      (hsync),
		.vsync      (vsync),
		.blank      (blank),
		.int_start  (int_start)
	);

	tb_dram_model dram (
		.clk        (clk),
		.reset      (reset),
		.dram_req   (dram_req),
		.dram_addr  (dram_addr),
		.dram_next  (dram_next),
		.dram_rdata (dram_rdata)
	);

	always #5 clk = ~clk;

	// one distinct colour ram entry per index
	function automatic video_pkg::color_t palette(input video_pkg::pix_t i);
		return {~i[6:0], i};
	endfunction

	function automatic video_pkg::dram_data_t fill_word(input video_pkg::dram_addr_t a);
		return a[15:0] ^ {3'b000, a[20:16], 8'h00} ^ 16'hA5C3;
	endfunction

	// byte shown at pixel p of window line l
	function automatic video_pkg::pix_t expected_byte(input video_pkg::pix_t page,
			input video_pkg::xoffs_t gx, input video_pkg::pix_t gy,
			input int l, input int p);
		video_pkg::dram_addr_t a;
		video_pkg::dram_data_t w;
		a[20:13] = page;
		a[12:5] = gy + video_pkg::pix_t'(l) - video_pkg::pix_t'(video_pkg::V_PIX_BEG);
		a[4:0] = gx + video_pkg::xoffs_t'(p / 2);
		w = fill_word(a);
		return (p % 2 == 1) ? w[15:8] : w[7:0];
	endfunction

	function automatic bit in_pixels(input int l, input int c);
		return l >= int'(video_pkg::V_PIX_BEG) && l < int'(video_pkg::V_PIX_END) &&
			c >= int'(video_pkg::H_PIX_BEG) && c < int'(video_pkg::H_PIX_END);
	endfunction

	// border of 4 lines and 8 columns around the window
	function automatic bit visible(input int l, input int c);
		return l >= int'(video_pkg::V_PIX_BEG) - 4 && l < int'(video_pkg::V_PIX_END) + 4 &&
			c >= 8 && c < 56;
	endfunction

	task automatic fail_run(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// strobe bits in order border, vpage, gx_offs, gy_offs, vconf
	task automatic cpu_write(input logic [4:0] strobe, input video_pkg::pix_t val);
		@(posedge clk);
		d <= val;
		{border_wr, vpage_wr, gx_offs_wr, gy_offs_wr, vconf_wr} <= strobe;
		if (strobe[4])
			stg_border = val;
		if (strobe[3])
			stg_vpage = val;
		if (strobe[2])
			stg_gx = val[4:0];
		if (strobe[1])
			stg_gy = val;
		if (strobe[0])
			stg_gfx = val[0];
		@(posedge clk);
		{border_wr, vpage_wr, gx_offs_wr, gy_offs_wr, vconf_wr} <= 5'b00000;
	endtask

	task automatic wait_frame_line(input int f, input int l);
		while (!(frame_no == f && line == l))
			@(posedge clk);
	endtask

	always @(negedge clk) begin : monitor
		logic              h_fall;
		logic              h_rise;
		logic              v_fall;
		logic              v_rise;
		video_pkg::pix_t   idx;
		if (reset) begin
			hs_d = 1'b1;
			vs_d = 1'b1;
			h_seen = 1'b0;
			v_seen = 1'b0;
			frame_no = -1;
			col = 0;
			line = 0;
			act_border = '0;
			act_vpage = '0;
			act_gy = '0;
			act_gx = '0;
			act_gfx = 1'b0;
		end else begin
			h_fall = hs_d && !hsync;
			h_rise = !hs_d && hsync;
			v_fall = vs_d && !vsync;
			v_rise = !vs_d && vsync;
			assert (int_start == (h_fall && v_fall))
				else fail_run("int_start not on the first sync cycle of the frame");
			assert (!v_fall || h_fall) else fail_run("vsync fell away from an hsync fall");
			if (h_fall) begin
				if (h_seen) begin
					assert (col + 1 == int'(video_pkg::H_TOTAL))
						else fail_run($sformatf("hsync period %0d", col + 1));
				end
				col = 0;
				h_seen = 1'b1;
				if (v_fall) begin
					if (v_seen) begin
						assert (line + 1 == int'(video_pkg::V_TOTAL))
							else fail_run($sformatf("vsync period %0d lines", line + 1));
					end
					line = 0;
					v_seen = 1'b1;
					frame_no++;
					// staged registers take effect at the frame start
					act_border = stg_border;
					act_vpage = stg_vpage;
					act_gy = stg_gy;
					act_gx = stg_gx;
					act_gfx = stg_gfx;
				end else begin
					line++;
				end
			end else begin
				col++;
			end
			if (h_rise) begin
				assert (col == int'(video_pkg::H_SYNC))
					else fail_run($sformatf("hsync low for %0d cycles", col));
			end
			if (v_rise) begin
				assert (h_fall && line == int'(video_pkg::V_SYNC))
					else fail_run($sformatf("vsync rose at line %0d col %0d", line, col));
			end
			if (v_seen) begin
				assert (blank == !visible(line, col))
					else fail_run($sformatf("blank %b at line %0d col %0d", blank, line, col));
				assert (!blank || rgb == '0)
					else fail_run($sformatf("rgb %h while blanked", rgb));
				assert (act_gfx || !dram_req)
					else fail_run("dram_req high with graphics off");
				if (frame_no >= 1 && !blank) begin
					if (act_gfx && in_pixels(line, col)) begin
						idx = expected_byte(act_vpage, act_gx, act_gy, line,
							col - int'(video_pkg::H_PIX_BEG));
						gfx_checks++;
					end else begin
						idx = act_border;
						if (in_pixels(line, col))
							off_checks++;
						else
							border_checks++;
					end
					assert (rgb == palette(idx))
						else fail_run($sformatf("rgb %h expected %h at line %0d col %0d",
							rgb, palette(idx), line, col));
				end
			end
			hs_d = hsync;
			vs_d = vsync;
		end
	end

	initial begin : stimulus
		int i;
		stg_border = '0;
		stg_vpage = '0;
		stg_gy = '0;
		stg_gx = '0;
		stg_gfx = 1'b0;
		reset <= 1'b1;
		d <= '0;
		{border_wr, vpage_wr, gx_offs_wr, gy_offs_wr, vconf_wr} <= 5'b00000;
		cram_we <= 1'b0;
		cram_addr <= '0;
		cram_wdata <= '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// colour ram filled before the first visible line
		for (i = 0; i < 256; i++) begin
			cram_we <= 1'b1;
			cram_addr <= video_pkg::pix_t'(i);
			cram_wdata <= palette(video_pkg::pix_t'(i));
			@(posedge clk);
		end
		cram_we <= 1'b0;

		// first setup with gy wrapping through 255 inside the window
		wait_frame_line(0, 8);
		cpu_write(5'b10000, 8'h3C);
		cpu_write(5'b01000, 8'h5A);
		cpu_write(5'b00100, 8'h03);
		cpu_write(5'b00010, 8'hFA);
		cpu_write(5'b00001, 8'h01);

		// second setup written during the window of frame 2
		wait_frame_line(2, 16);
		cpu_write(5'b10000, 8'h81);
		cpu_write(5'b01000, 8'hC7);
		cpu_write(5'b00100, 8'h1D);
		cpu_write(5'b00010, 8'h11);

		// graphics off from frame 4
		wait_frame_line(3, 16);
		cpu_write(5'b00001, 8'h00);
		cpu_write(5'b10000, 8'h0F);

		wait_frame_line(5, 0);
		if (gfx_checks == 0 || border_checks == 0 || off_checks == 0) begin
			fail_run("some pixel checks were never reached");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

	// six frames of run time plus setup margin
	initial begin : watchdog
		int frame_cycles;
		frame_cycles = int'(video_pkg::H_TOTAL) * int'(video_pkg::V_TOTAL);
		#((6 * frame_cycles + 2000) * 10);
		fail_run("watchdog expired before the test sequence finished");
	end

endmodule
